/* eth_tx_settings.svh */
`ifndef ETH_TX_SETTINGS_SVH
`define ETH_TX_SETTINGS_SVH

// default station addresses, bits 47:40 are the first byte on the wire
`define ETH_DST_MAC         48'h00_E0_4C_68_1E_0C
`define ETH_SRC_MAC         48'h69_69_5A_06_54_91

// fixed byte values of the frame start
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD_BYTE        8'hD5

// field lengths in bytes
`define ETH_PREAMBLE_BYTES  7
`define ETH_MAC_BYTES       6
`define ETH_TYPE_BYTES      2
`define ETH_DATA_BYTES      2
`define ETH_PAD_BYTES       44
`define ETH_FCS_BYTES       4

// bytes sent while txen is high, preamble through fcs
`define ETH_FRAME_BYTES     72

// idle cycles between frames, 96 bit times at two bits per cycle
`define ETH_IPG_CYCLES      48

`endif

/* eth_tx_pkg.sv */
package eth_tx_pkg;

    // frame sequencer states, in the order the fields leave the MAC
    typedef enum logic [3:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DST_MAC,
        SRC_MAC,
        ETHERTYPE,
        PAYLOAD,
        ZERO_PAD,
        DRAIN,
        FCS,
        IPG
    } tx_state_t;

    // one frame request, latched at start
    typedef struct packed {
        logic [15:0] ethertype;
        logic [15:0] payload;
    } tx_req_t;

    // internal dibit stream between sequencer, bitorder and crc
    typedef struct packed {
        logic       valid;
        logic [1:0] d;
    } dibit_t;

    // rmii transmit pins, txd[0] is the earlier bit on the wire
    typedef struct packed {
        logic       txen;
        logic [1:0] txd;
    } rmii_t;

endpackage

/* bitorder.sv */
module bitorder (
    input  logic               clk,
    input  logic               rst,
    input  eth_tx_pkg::dibit_t in,
    output eth_tx_pkg::dibit_t out
);

    // double buffer, one half fills while the other replays
    logic [7:0] half [2];
    logic       wr_sel;
    logic [1:0] fill_cnt;
    logic [1:0] rd_cnt;
    logic       rd_active;
    logic       byte_done;

    assign byte_done = in.valid && (fill_cnt == 2'd3);

    // incoming dibits arrive msb first, so the first one lands in 7:6
    always_ff @(posedge clk) begin
        if (in.valid) begin
            half[wr_sel][7 - 2 * fill_cnt -: 2] <= in.d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_sel    <= 1'b0;
            fill_cnt  <= 2'd0;
            rd_cnt    <= 2'd0;
            rd_active <= 1'b0;
        end else begin
            if (in.valid) begin
                fill_cnt <= fill_cnt + 2'd1;
            end
            // a full byte swaps halves and restarts the replay
            if (byte_done) begin
                wr_sel    <= !wr_sel;
                rd_cnt    <= 2'd0;
                rd_active <= 1'b1;
            end else if (rd_active) begin
                rd_cnt <= rd_cnt + 2'd1;
                if (rd_cnt == 2'd3) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    // replay lsb pair first: 1:0, 3:2, 5:4, 7:6
    always_comb begin
        out.valid = rd_active;
        out.d     = half[!wr_sel][2 * rd_cnt +: 2];
    end

endmodule

/* crc32.sv */
module crc32 (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  eth_tx_pkg::dibit_t in,
    output logic [31:0]        crc
);

    // reflected form of the ieee 802.3 polynomial 04C11DB7
    localparam logic [31:0] POLY = 32'hEDB88320;

    // two serial lfsr steps, d[0] is the earlier bit on the wire
    function automatic logic [31:0] step2(input logic [31:0] c, input logic [1:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 2; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= '1;
        end else if (in.valid) begin
            crc <= step2(crc, in.d);
        end
    end

endmodule

/* mac_tx.sv */
`include "eth_tx_settings.svh"

module mac_tx #(
    parameter logic [47:0] SRC_MAC = `ETH_SRC_MAC,
    parameter logic [47:0] DST_MAC = `ETH_DST_MAC
) (
    input  logic                clk,
    input  logic                rst,
    input  eth_tx_pkg::tx_req_t req,
    input  logic                start,
    output logic                busy,
    output eth_tx_pkg::rmii_t   tx
);

    import eth_tx_pkg::*;

    // field lengths in dibits
    localparam int PRE_LEN   = `ETH_PREAMBLE_BYTES * 4;
    localparam int SFD_LEN   = 4;
    localparam int MAC_LEN   = `ETH_MAC_BYTES * 4;
    localparam int TYPE_LEN  = `ETH_TYPE_BYTES * 4;
    localparam int DATA_LEN  = `ETH_DATA_BYTES * 4;
    localparam int PAD_LEN   = `ETH_PAD_BYTES * 4;
    localparam int DRAIN_LEN = 4;
    localparam int FCS_LEN   = `ETH_FCS_BYTES * 4;
    // one extra cycle since the pins lag the sequencer by the output register
    localparam int IPG_LEN   = `ETH_IPG_CYCLES + 1;

    localparam logic [7:0] PRE_BYTE = `ETH_PREAMBLE_BYTE;
    localparam logic [7:0] SFD_BYTE = `ETH_SFD_BYTE;

    tx_state_t   state;
    tx_state_t   succ;
    logic [8:0]  cnt;
    logic [8:0]  state_len;
    logic        state_done;
    logic        accept;
    logic        advance;
    tx_req_t     req_q;
    dibit_t      field;
    dibit_t      ordered;
    dibit_t      crc_in;
    logic        crc_en;
    logic [31:0] crc;
    logic [31:0] fcs;
    rmii_t       tx_next;

    // length of each state
    // the address parameters hide the like-named states, hence the scoped names
    always_comb begin
        case (state)
            PREAMBLE:            state_len = 9'(PRE_LEN);
            SFD:                 state_len = 9'(SFD_LEN);
            eth_tx_pkg::DST_MAC: state_len = 9'(MAC_LEN);
            eth_tx_pkg::SRC_MAC: state_len = 9'(MAC_LEN);
            ETHERTYPE:           state_len = 9'(TYPE_LEN);
            PAYLOAD:             state_len = 9'(DATA_LEN);
            ZERO_PAD:            state_len = 9'(PAD_LEN);
            DRAIN:               state_len = 9'(DRAIN_LEN);
            FCS:                 state_len = 9'(FCS_LEN);
            IPG:                 state_len = 9'(IPG_LEN);
            default:             state_len = 9'd1;
        endcase
    end

    // successor of each state, fields in frame order
    always_comb begin
        case (state)
            IDLE:                succ = PREAMBLE;
            PREAMBLE:            succ = SFD;
            SFD:                 succ = eth_tx_pkg::DST_MAC;
            eth_tx_pkg::DST_MAC: succ = eth_tx_pkg::SRC_MAC;
            eth_tx_pkg::SRC_MAC: succ = ETHERTYPE;
            ETHERTYPE:           succ = PAYLOAD;
            PAYLOAD:             succ = ZERO_PAD;
            ZERO_PAD:            succ = DRAIN;
            DRAIN:               succ = FCS;
            FCS:                 succ = IPG;
            default:             succ = IDLE;
        endcase
    end

    assign state_done = (cnt == state_len - 9'd1);
    assign accept     = (state == IDLE) && start;
    assign advance    = (state == IDLE) ? start : state_done;
    assign busy       = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= 9'd0;
        end else if (advance) begin
            state <= succ;
            cnt   <= 9'd0;
        end else if (state != IDLE) begin
            cnt <= cnt + 9'd1;
        end
    end

    // request held for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // source byte of each field, presented msb dibit first
    always_comb begin
        field.valid = 1'b1;
        field.d     = 2'b00;
        case (state)
            PREAMBLE:            field.d = PRE_BYTE[7 - 2 * cnt[1:0] -: 2];
            SFD:                 field.d = SFD_BYTE[7 - 2 * cnt[1:0] -: 2];
            eth_tx_pkg::DST_MAC: field.d = DST_MAC[47 - 2 * cnt -: 2];
            eth_tx_pkg::SRC_MAC: field.d = SRC_MAC[47 - 2 * cnt -: 2];
            ETHERTYPE:           field.d = req_q.ethertype[15 - 2 * cnt -: 2];
            PAYLOAD:             field.d = req_q.payload[15 - 2 * cnt -: 2];
            ZERO_PAD:            field.d = 2'b00;
            default:             field.valid = 1'b0;
        endcase
    end

    bitorder u_bitorder (
        .clk (clk),
        .rst (rst),
        .in  (field),
        .out (ordered)
    );

    // bitorder runs one byte behind, so the first address byte reaches
    // the crc four dibits into DST_MAC and the last pad byte during DRAIN
    always_comb begin
        case (state)
            eth_tx_pkg::DST_MAC:                                        crc_en = (cnt >= 9'd4);
            eth_tx_pkg::SRC_MAC, ETHERTYPE, PAYLOAD, ZERO_PAD, DRAIN:   crc_en = 1'b1;
            default:                                                    crc_en = 1'b0;
        endcase
    end

    always_comb begin
        crc_in.valid = ordered.valid && crc_en;
        crc_in.d     = ordered.d;
    end

    crc32 u_crc32 (
        .clk   (clk),
        .rst   (rst),
        .clear (accept),
        .in    (crc_in),
        .crc   (crc)
    );

    assign fcs = ~crc;

    // fcs goes out bit 0 first, which also puts its low byte first
    always_comb begin
        if (state == FCS) begin
            tx_next.txen = 1'b1;
            tx_next.txd  = fcs[2 * cnt[3:0] +: 2];
        end else begin
            tx_next.txen = ordered.valid;
            tx_next.txd  = ordered.valid ? ordered.d : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx <= '0;
        end else begin
            tx <= tx_next;
        end
    end

endmodule

/* rmii_tx_top.sv */
module rmii_tx_top (
    input  logic                clk,
    input  logic                rst,
    input  eth_tx_pkg::tx_req_t req,
    input  logic                start,
    output logic                busy,
    output eth_tx_pkg::rmii_t   tx
);

    // transmit mac with the default station addresses
    mac_tx u_mac_tx (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .start (start),
        .busy  (busy),
        .tx    (tx)
    );

endmodule

/* tx_frame_checker.sv */
`include "eth_tx_settings.svh"

module tx_frame_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                busy,
    input  eth_tx_pkg::rmii_t   tx,
    input  logic                exp_push,
    input  eth_tx_pkg::tx_req_t exp_req,
    output int                  errors,
    output int                  frames_done
);

    import eth_tx_pkg::*;

    // byte offsets within the frame
    localparam int DST_AT  = `ETH_PREAMBLE_BYTES + 1;
    localparam int TYPE_AT = DST_AT + 12;
    localparam int PAD_AT  = TYPE_AT + 4;
    localparam int FCS_AT  = PAD_AT + `ETH_PAD_BYTES;

    // sample offsets from the start edge, a pin change shows at the next sample
    localparam int TXEN_FIRST = 6;
    localparam int TXEN_LAST  = TXEN_FIRST + `ETH_FRAME_BYTES * 4 - 1;
    localparam int BUSY_LOW   = TXEN_LAST + 1 + `ETH_IPG_CYCLES;

    tx_req_t     pending [$];
    tx_req_t     cur_req;
    logic [31:0] cur_fcs;
    logic        active = 1'b0;
    int          rel;
    int          frame_errs;
    logic [7:0]  rx_byte;

    initial begin
        errors      = 0;
        frames_done = 0;
    end

    // byte i of the frame in wire order, fcs low byte first
    function automatic logic [7:0] frame_byte(input tx_req_t r, input logic [31:0] f, input int i);
        logic [47:0] dst;
        logic [47:0] src;
        dst = `ETH_DST_MAC;
        src = `ETH_SRC_MAC;
        if (i < DST_AT - 1) return 8'h55;
        if (i == DST_AT - 1) return 8'hD5;
        if (i < DST_AT + 6) return 8'(dst >> (8 * (DST_AT + 5 - i)));
        if (i < TYPE_AT) return 8'(src >> (8 * (TYPE_AT - 1 - i)));
        if (i < PAD_AT) return 8'({r.ethertype, r.payload} >> (8 * (PAD_AT - 1 - i)));
        if (i < FCS_AT) return 8'h00;
        return 8'(f >> (8 * (i - FCS_AT)));
    endfunction

    // byte-wise reflected crc-32, destination address through padding
    function automatic logic [31:0] reference_fcs(input tx_req_t r);
        logic [31:0] c;
        c = '1;
        for (int i = DST_AT; i < FCS_AT; i++) begin
            c ^= {24'd0, frame_byte(r, 32'd0, i)};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
            end
        end
        return ~c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, want, got);
        errors++;
        frame_errs++;
    endtask

    task automatic check_frame_cycle();
        logic       exp_en;
        int         pos;
        logic [7:0] want;
        exp_en = (rel >= TXEN_FIRST) && (rel <= TXEN_LAST);
        pos    = rel - TXEN_FIRST;
        if (busy !== 1'b1) report_mismatch("busy", 1, busy);
        if (tx.txen !== exp_en) report_mismatch("tx.txen", exp_en, tx.txen);
        if (!exp_en && tx.txd !== 2'b00) report_mismatch("tx.txd", 0, tx.txd);
        if (exp_en) begin
            // dibits arrive bits 1:0 of each byte first
            rx_byte[2 * (pos % 4) +: 2] = tx.txd;
            want = frame_byte(cur_req, cur_fcs, pos / 4);
            if (pos % 4 == 3 && rx_byte !== want) begin
                report_mismatch($sformatf("tx.txd byte %0d", pos / 4), want, rx_byte);
            end
        end
    endtask

    task automatic finish_frame();
        frames_done++;
        $display("frame %0d: ethertype %h payload %h fcs %h, %0d errors",
                 frames_done, cur_req.ethertype, cur_req.payload, cur_fcs, frame_errs);
        active = 1'b0;
    endtask

    always @(posedge clk) begin
        if (exp_push) begin
            pending.push_back(exp_req);
        end
        if (rst) begin
            active = 1'b0;
        end else begin
            if (active) begin
                rel++;
                if (rel == BUSY_LOW) finish_frame();
                else check_frame_cycle();
            end
            if (!active && start && !busy) begin
                // start with busy low is taken on this edge
                if (pending.size() == 0) begin
                    $display("error at %0t: frame started with no request from stimulus",
                             $time);
                    errors++;
                end else begin
                    cur_req = pending.pop_front();
                end
                cur_fcs    = reference_fcs(cur_req);
                active     = 1'b1;
                rel        = 0;
                frame_errs = 0;
            end else if (!active) begin
                if (busy !== 1'b0) report_mismatch("busy", 0, busy);
                if (tx.txen !== 1'b0) report_mismatch("tx.txen", 0, tx.txen);
                if (tx.txd !== 2'b00) report_mismatch("tx.txd", 0, tx.txd);
            end
        end
    end

endmodule

/* tb_rmii_tx.sv */
`include "eth_tx_settings.svh"

module tb_rmii_tx;

    import eth_tx_pkg::*;

    localparam int MAX_LINES = 64;

    logic        clk;
    logic        rst;
    logic        start;
    logic        busy;
    tx_req_t     req;
    rmii_t       tx;
    logic        exp_push;
    tx_req_t     exp_req;
    int          errors;
    int          frames_done;
    logic [15:0] vec [0:4*MAX_LINES-1];
    int          nlines;
    int          max_wait;
    int          limit = 0;
    int          cycles = 0;

    rmii_tx_top UUT (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .start (start),
        .busy  (busy),
        .tx    (tx)
    );

    tx_frame_checker u_frame_checker (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .tx          (tx),
        .exp_push    (exp_push),
        .exp_req     (exp_req),
        .errors      (errors),
        .frames_done (frames_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d frames seen",
                     cycles, frames_done, nlines);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input int idle, input tx_req_t r, input int restart);
        while (busy) next_cycle();
        repeat (idle) next_cycle();
        req      = r;
        start    = 1'b1;
        exp_push = 1'b1;
        exp_req  = r;
        next_cycle();
        // request is latched, so scramble it while the frame runs
        req      = ~r;
        start    = 1'b0;
        exp_push = 1'b0;
        if (restart > 0) begin
            repeat (restart - 1) next_cycle();
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
    endtask

    initial begin
        rst      = 1'b1;
        start    = 1'b0;
        req      = '0;
        exp_push = 1'b0;
        exp_req  = '0;
        $readmemh("rmii_tx_testdata.txt", vec);
        nlines   = 0;
        max_wait = 0;
        while (nlines < MAX_LINES && !$isunknown(vec[4 * nlines])
               && vec[4 * nlines] != 16'hFFFF) begin
            if (vec[4 * nlines] > max_wait) max_wait = vec[4 * nlines];
            nlines++;
        end
        limit = nlines * (`ETH_FRAME_BYTES * 4 + `ETH_IPG_CYCLES + max_wait + 20);
        repeat (4) next_cycle();
        rst = 1'b0;
        for (int i = 0; i < nlines; i++) begin
            send_frame(vec[4 * i], {vec[4 * i + 1], vec[4 * i + 2]}, vec[4 * i + 3]);
        end
        while (frames_done < nlines) next_cycle();
        // quiet tail where a spurious frame would show up
        repeat (20) next_cycle();
        $display("frames checked %0d of %0d, errors %0d", frames_done, nlines, errors);
        if (errors == 0 && nlines > 0 && frames_done == nlines) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* rmii_tx_testdata.txt */
// idle cycles, ethertype, payload, extra start pulse (cycles after the start edge, 0 none)
// all hex, a line of ffff ends the list
0003 0800 0000 0000
0000 0800 FFFF 0000
0000 86DD A5C3 0096
0005 88B5 1234 0001
000A 0806 FFFF 0154
0000 FFFF 0000 0000
0002 0000 5A5A 0000
0000 1234 8001 00C8
0007 88CC 00FF 0000
FFFF FFFF FFFF FFFF

/* files.f */
+incdir+.
eth_tx_pkg.sv
bitorder.sv
crc32.sv
mac_tx.sv
rmii_tx_top.sv
tx_frame_checker.sv
tb_rmii_tx.sv
